/* tb.f */
+incdir+test
hw/mode_regs_pkg.sv
hw/video_timing_pkg.sv
hw/mode_reg_bank.sv
hw/mode_matcher.sv
hw/timing_calc.sv
hw/mode_banks_top.sv
test/mode_banks_properties.sv
test/mode_banks_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the mode bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module mode_banks_tb -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

./obj_dir/Vmode_banks_tb 2>&1 | tee sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation ended without passing"; exit 1; }

/* test/mode_banks_model.svh */
`ifndef MODE_BANKS_MODEL_SVH
`define MODE_BANKS_MODEL_SVH

// shadow copy of the register bank
mode_cfg_t            model_cfg [num_modes];
logic [num_modes-1:0] model_valid;
logic [num_modes-1:0] model_dirty;
int                   model_last;

// counter limits as the output side expects them, 16-bit wrap
function automatic video_timing_t expected_timing(input mode_cfg_t cfg);
    video_timing_t t;
    logic [15:0]   hs;
    logic [15:0]   vs;
    hs = cfg.sample_count + cfg.h_front_porch;
    vs = cfg.line_count + cfg.v_front_porch;
    t.h_total_minus_one = cfg.sample_count + cfg.h_blank - 16'd1;
    t.v_total_minus_one = cfg.line_count + cfg.v_blank - 16'd1;
    t.h_blank = cfg.h_blank;
    t.v_blank = cfg.v_blank;
    t.h_sync_start = hs;
    t.h_sync_end = hs + cfg.h_sync_length;
    t.v_sync_start = vs;
    t.v_sync_end = vs + cfg.v_sync_length;
    return t;
endfunction

task automatic model_reset();
    model_valid = '0;
    model_dirty = '0;
    model_last = -1;
endtask

task automatic model_write(input logic [7:0] addr, input logic [15:0] data);
    int rel;
    int m;
    int off;
    rel = int'(addr) - mode_base_addr;
    if (rel >= 0 && rel < num_modes * mode_stride) begin
        m = rel / mode_stride;
        off = rel % mode_stride;
        if (off == reg_valid) begin
            model_valid[m] = data[0];
            if (data[0]) begin
                model_dirty[m] = 1'b1;
            end
        end else if (!model_valid[m]) begin
            case (off)
                reg_sample_count:  model_cfg[m].sample_count = data;
                reg_line_count:    model_cfg[m].line_count = data;
                reg_h_front_porch: model_cfg[m].h_front_porch = data;
                reg_h_sync_length: model_cfg[m].h_sync_length = data;
                reg_h_blank:       model_cfg[m].h_blank = data;
                reg_v_front_porch: model_cfg[m].v_front_porch = data;
                reg_v_sync_length: model_cfg[m].v_sync_length = data;
                reg_v_blank:       model_cfg[m].v_blank = data;
                default: ;
            endcase
        end
    end
endtask

// lowest valid mode of that size, -1 if none
function automatic int model_find(input logic [15:0] samples, input logic [15:0] lines);
    int idx;
    idx = -1;
    for (int i = num_modes - 1; i >= 0; i--) begin
        if (model_valid[i] && model_cfg[i].sample_count == samples &&
            model_cfg[i].line_count == lines) begin
            idx = i;
        end
    end
    return idx;
endfunction

task automatic model_accept(input int idx);
    model_last = idx;
    model_dirty[idx] = 1'b0;
endtask

`endif

/* test/mode_banks_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mode_banks_tb;

    import mode_regs_pkg::*;
    import video_timing_pkg::*;

    logic                 clk;
    logic                 rst;
    logic                 reg_write;
    reg_wr_t              reg_wr;
    logic                 find_mode_req;
    video_meas_t          meas;
    logic [num_modes-1:0] mode_match_safe;
    logic                 dirty_modes;
    logic                 mode_change;
    logic                 vid_mode_change;
    video_timing_t        timing;

    integer               seed;
    int                   pick;
    mode_cfg_t            cfg;
    logic [15:0]          new_blank;

    `include "mode_banks_model.svh"

    mode_banks_top i_mode_banks_top (
        .clk             (clk),
        .rst             (rst),
        .reg_write       (reg_write),
        .reg_wr          (reg_wr),
        .find_mode_req   (find_mode_req),
        .meas            (meas),
        .mode_match_safe (mode_match_safe),
        .dirty_modes     (dirty_modes),
        .mode_change     (mode_change),
        .vid_mode_change (vid_mode_change),
        .timing          (timing)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [7:0] mode_addr(input int m, input int off);
        return 8'(mode_base_addr + m * mode_stride + off);
    endfunction

    // one strobe starting on a falling edge
    task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
        reg_write = 1'b1;
        reg_wr.addr = addr;
        reg_wr.data = data;
        model_write(addr, data);
        @(negedge clk);
        reg_write = 1'b0;
    endtask

    task automatic make_random_cfg(input int m, output mode_cfg_t c);
        // sizes kept apart per mode so only the priority test overlaps them
        c.sample_count = 16'((m + 1) * 512 + ($random(seed) & 255));
        c.line_count = 16'(200 + m * 256 + ($random(seed) & 127));
        c.h_front_porch = 16'(1 + ($random(seed) & 127));
        c.h_sync_length = 16'(1 + ($random(seed) & 63));
        c.h_blank = 16'(200 + ($random(seed) & 255));
        c.v_front_porch = 16'(1 + ($random(seed) & 7));
        c.v_sync_length = 16'(1 + ($random(seed) & 7));
        c.v_blank = 16'(20 + ($random(seed) & 31));
    endtask

    task automatic program_mode(input int m, input mode_cfg_t c);
        write_reg(mode_addr(m, reg_sample_count), c.sample_count);
        write_reg(mode_addr(m, reg_line_count), c.line_count);
        write_reg(mode_addr(m, reg_h_front_porch), c.h_front_porch);
        write_reg(mode_addr(m, reg_h_sync_length), c.h_sync_length);
        write_reg(mode_addr(m, reg_h_blank), c.h_blank);
        write_reg(mode_addr(m, reg_v_front_porch), c.v_front_porch);
        write_reg(mode_addr(m, reg_v_sync_length), c.v_sync_length);
        write_reg(mode_addr(m, reg_v_blank), c.v_blank);
    endtask

    task automatic wait_mode_change(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!vid_mode_change && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!vid_mode_change) begin
            $display("timeout: the mode change to mode %0d never arrived", idx);
            $display("CHECKS FAILED");
            $fatal(1, "mode change timeout");
        end
    endtask

    // search for a size and compare against the model decision
    task automatic select_size(input logic [15:0] samples, input logic [15:0] lines);
        int                   idx;
        logic                 exp_change;
        logic [num_modes-1:0] exp_match;
        video_timing_t        prev;
        idx = model_find(samples, lines);
        exp_change = idx >= 0 && (idx != model_last || model_dirty[idx]);
        exp_match = (idx >= 0) ? num_modes'(1 << idx) : '0;
        prev = timing;
        meas.samples = samples;
        meas.lines = lines;
        find_mode_req = 1'b1;
        if (exp_change) begin
            wait_mode_change(idx);
            check_value("selection timing", expected_timing(model_cfg[idx]), timing);
            check_value("selection match", exp_match, mode_match_safe);
            // decision is gone once the new mode is accepted
            check_value("mode_change after pulse", 1'b0, mode_change);
            model_accept(idx);
        end else begin
            repeat (20) begin
                @(negedge clk);
                check_value("unexpected mode change", 1'b0, vid_mode_change);
            end
            check_value("held timing", prev, timing);
            check_value("held match", exp_match, mode_match_safe);
        end
        find_mode_req = 1'b0;
        @(negedge clk);
        @(negedge clk);
        check_value("dirty flags", |model_dirty, dirty_modes);
    endtask

    task automatic select_mode(input int m);
        select_size(model_cfg[m].sample_count, model_cfg[m].line_count);
    endtask

    initial begin
        seed = 32'h4b5cd4bf;
        rst = 1'b1;
        reg_write = 1'b0;
        reg_wr = '0;
        find_mode_req = 1'b0;
        meas = '0;
        model_reset();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_value("reset timing", expected_timing(default_mode), timing);
        check_value("reset vid_mode_change", 1'b0, vid_mode_change);
        check_value("reset mode_change", 1'b0, mode_change);
        check_value("reset dirty_modes", 1'b0, dirty_modes);
        check_value("reset match", '0, mode_match_safe);

        for (int m = 0; m < num_modes; m++) begin
            make_random_cfg(m, cfg);
            program_mode(m, cfg);
        end
        for (int m = 0; m < num_modes; m++) begin
            write_reg(mode_addr(m, reg_valid), 16'd1);
        end
        @(negedge clk);
        check_value("dirty after programming", 1'b1, dirty_modes);

        repeat (10) begin
            pick = $random(seed) & 3;
            select_mode(pick);
        end
        for (int m = 0; m < num_modes; m++) begin
            select_mode(m);
        end
        check_value("dirty after all selected", 1'b0, dirty_modes);

        // mode 2 takes the size of mode 1
        write_reg(mode_addr(2, reg_valid), 16'd0);
        write_reg(mode_addr(2, reg_sample_count), model_cfg[1].sample_count);
        write_reg(mode_addr(2, reg_line_count), model_cfg[1].line_count);
        write_reg(mode_addr(2, reg_valid), 16'd1);
        select_mode(3);
        select_mode(1);
        check_value("priority match", 4'b0010, mode_match_safe);

        // locked write is dropped
        new_blank = model_cfg[0].h_blank + 16'h0100;
        write_reg(mode_addr(0, reg_h_blank), new_blank);
        select_mode(3);
        select_mode(0);
        check_value("locked h_blank", model_cfg[0].h_blank, timing.h_blank);
        write_reg(mode_addr(0, reg_valid), 16'd0);
        write_reg(mode_addr(0, reg_h_blank), new_blank);
        write_reg(mode_addr(0, reg_valid), 16'd1);
        select_mode(0);
        check_value("rewritten h_blank", new_blank, timing.h_blank);

        select_size(16'hffff, 16'hffff);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/mode_banks_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module mode_banks_properties (
    input wire logic                                 clk,
    input wire logic                                 rst,
    input wire logic [mode_regs_pkg::num_modes-1:0]  mode_match_safe,
    input wire logic                                 mode_change,
    input wire logic                                 vid_mode_change,
    input wire video_timing_pkg::video_timing_t      timing
);

    // priority select leaves at most one mode
    one_match: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mode_match_safe))
        else $error("more than one mode selected");

    change_follows: assert property (@(posedge clk) disable iff (rst)
        vid_mode_change |-> $past(mode_change))
        else $error("output pulse without a preceding change decision");

    // output counters only move with the pulse
    timing_held: assert property (@(posedge clk) disable iff (rst)
        !vid_mode_change |-> $stable(timing))
        else $error("timing moved without a mode change");

endmodule

bind mode_banks_top mode_banks_properties i_mode_banks_properties (
    .clk             (clk),
    .rst             (rst),
    .mode_match_safe (mode_match_safe),
    .mode_change     (mode_change),
    .vid_mode_change (vid_mode_change),
    .timing          (timing)
);

`default_nettype wire

/* hw/mode_banks_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mode_banks_top (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                reg_write,
    input  wire mode_regs_pkg::reg_wr_t              reg_wr,
    input  wire logic                                find_mode_req,
    input  wire video_timing_pkg::video_meas_t       meas,
    output logic [mode_regs_pkg::num_modes-1:0]      mode_match_safe,
    output logic                                     dirty_modes,
    output logic                                     mode_change,
    output logic                                     vid_mode_change,
    output video_timing_pkg::video_timing_t          timing
);

    import mode_regs_pkg::*;
    import video_timing_pkg::*;

    mode_cfg_t [num_modes-1:0] mode_cfgs;
    logic [num_modes-1:0]      valid_modes;
    logic [num_modes-1:0]      dirty_mode;
    mode_cfg_t                 sel_cfg;

    mode_reg_bank i_mode_reg_bank (
        .clk             (clk),
        .rst             (rst),
        .reg_write       (reg_write),
        .reg_wr          (reg_wr),
        .mode_change     (mode_change),
        .mode_match_safe (mode_match_safe),
        .mode_cfgs       (mode_cfgs),
        .valid_modes     (valid_modes),
        .dirty_mode      (dirty_mode),
        .dirty_modes     (dirty_modes)
    );

    mode_matcher i_mode_matcher (
        .clk             (clk),
        .rst             (rst),
        .find_mode_req   (find_mode_req),
        .meas            (meas),
        .mode_cfgs       (mode_cfgs),
        .valid_modes     (valid_modes),
        .dirty_mode      (dirty_mode),
        .mode_match_safe (mode_match_safe),
        .mode_change     (mode_change),
        .sel_cfg         (sel_cfg)
    );

    timing_calc i_timing_calc (
        .clk             (clk),
        .rst             (rst),
        .mode_change     (mode_change),
        .sel_cfg         (sel_cfg),
        .timing          (timing),
        .vid_mode_change (vid_mode_change)
    );

endmodule

`default_nettype wire

/* hw/timing_calc.sv */
`timescale 1ns/100ps
`default_nettype none

module timing_calc (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          mode_change,
    input  wire video_timing_pkg::mode_cfg_t   sel_cfg,
    output video_timing_pkg::video_timing_t    timing,
    output logic                               vid_mode_change
);

    import video_timing_pkg::*;

    video_timing_t next_timing;

    // counter limits from one mode, all sums wrap at 16 bits
    function automatic video_timing_t calc_timing(input mode_cfg_t cfg);
        video_timing_t t;
        t.h_total_minus_one = cfg.sample_count + cfg.h_blank - 16'd1;
        t.v_total_minus_one = cfg.line_count + cfg.v_blank - 16'd1;
        t.h_blank = cfg.h_blank;
        t.h_sync_start = cfg.sample_count + cfg.h_front_porch;
        t.h_sync_end = t.h_sync_start + cfg.h_sync_length;
        t.v_blank = cfg.v_blank;
        t.v_sync_start = cfg.line_count + cfg.v_front_porch;
        t.v_sync_end = t.v_sync_start + cfg.v_sync_length;
        return t;
    endfunction

    assign next_timing = calc_timing(sel_cfg);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timing <= calc_timing(default_mode);
            vid_mode_change <= 1'b0;
        end else begin
            vid_mode_change <= mode_change;
            if (mode_change) begin
                timing <= next_timing;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mode_matcher.sv */
`timescale 1ns/100ps
`default_nettype none

module mode_matcher (
    input  wire logic                                                   clk,
    input  wire logic                                                   rst,
    input  wire logic                                                   find_mode_req,
    input  wire video_timing_pkg::video_meas_t                          meas,
    input  wire video_timing_pkg::mode_cfg_t [mode_regs_pkg::num_modes-1:0] mode_cfgs,
    input  wire logic [mode_regs_pkg::num_modes-1:0]                    valid_modes,
    input  wire logic [mode_regs_pkg::num_modes-1:0]                    dirty_mode,
    output logic [mode_regs_pkg::num_modes-1:0]                         mode_match_safe,
    output logic                                                        mode_change,
    output video_timing_pkg::mode_cfg_t                                 sel_cfg
);

    import mode_regs_pkg::*;

    logic [num_modes-1:0]  mode_match;
    logic [num_modes-1:0]  last_match;
    logic                  find_mode;
    logic [mode_idx_w-1:0] sel_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_match <= '0;
            find_mode <= 1'b0;
            last_match <= '0;
        end else begin
            find_mode <= find_mode_req;
            for (int i = 0; i < num_modes; i++) begin
                mode_match[i] <= valid_modes[i] &&
                                 mode_cfgs[i].sample_count == meas.samples &&
                                 mode_cfgs[i].line_count == meas.lines;
            end
            // match currently driving the output timing
            if (mode_change) begin
                last_match <= mode_match_safe;
            end
        end
    end

    // lowest index wins
    always_comb begin
        for (int i = 0; i < num_modes; i++) begin
            mode_match_safe[i] = mode_match[i];
            for (int j = 0; j < i; j++) begin
                if (mode_match[j]) begin
                    mode_match_safe[i] = 1'b0;
                end
            end
        end
    end

    // one-hot to index
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < num_modes; i++) begin
            if (mode_match_safe[i]) begin
                sel_idx = sel_idx | mode_idx_w'(i);
            end
        end
    end

    assign sel_cfg = mode_cfgs[sel_idx];

    // new mode, or same mode reprogrammed since it was last taken
    assign mode_change = find_mode && (|mode_match_safe) &&
                         ((|(mode_match_safe ^ last_match)) || dirty_mode[sel_idx]);

endmodule

`default_nettype wire

/* hw/mode_reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module mode_reg_bank (
    input  wire logic                                                    clk,
    input  wire logic                                                    rst,
    input  wire logic                                                    reg_write,
    input  wire mode_regs_pkg::reg_wr_t                                  reg_wr,
    input  wire logic                                                    mode_change,
    input  wire logic [mode_regs_pkg::num_modes-1:0]                     mode_match_safe,
    output video_timing_pkg::mode_cfg_t [mode_regs_pkg::num_modes-1:0] mode_cfgs,
    output logic [mode_regs_pkg::num_modes-1:0]                          valid_modes,
    output logic [mode_regs_pkg::num_modes-1:0]                          dirty_mode,
    output logic                                                         dirty_modes
);

    import mode_regs_pkg::*;

    logic [num_modes-1:0] wr_sel;
    int                   wr_off;

    // address to mode select and offset
    always_comb begin
        wr_sel = '0;
        wr_off = 0;
        for (int i = 0; i < num_modes; i++) begin
            if (int'(reg_wr.addr) >= mode_base_addr + i * mode_stride &&
                int'(reg_wr.addr) < mode_base_addr + (i + 1) * mode_stride) begin
                wr_sel[i] = reg_write;
                wr_off = int'(reg_wr.addr) - (mode_base_addr + i * mode_stride);
            end
        end
    end

    // config storage, locked while the mode is valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_modes; i++) begin
            if (wr_sel[i] && !valid_modes[i] && wr_off < regs_per_mode) begin
                case (wr_off)
                    reg_sample_count:  mode_cfgs[i].sample_count <= reg_wr.data;
                    reg_line_count:    mode_cfgs[i].line_count <= reg_wr.data;
                    reg_h_front_porch: mode_cfgs[i].h_front_porch <= reg_wr.data;
                    reg_h_sync_length: mode_cfgs[i].h_sync_length <= reg_wr.data;
                    reg_h_blank:       mode_cfgs[i].h_blank <= reg_wr.data;
                    reg_v_front_porch: mode_cfgs[i].v_front_porch <= reg_wr.data;
                    reg_v_sync_length: mode_cfgs[i].v_sync_length <= reg_wr.data;
                    reg_v_blank:       mode_cfgs[i].v_blank <= reg_wr.data;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_modes <= '0;
            dirty_mode <= '0;
            dirty_modes <= 1'b0;
        end else begin
            for (int i = 0; i < num_modes; i++) begin
                if (wr_sel[i] && wr_off == reg_valid) begin
                    valid_modes[i] <= reg_wr.data[0];
                end
                // a fresh lock wins over a clear in the same cycle
                if (wr_sel[i] && wr_off == reg_valid && reg_wr.data[0]) begin
                    dirty_mode[i] <= 1'b1;
                end else if (mode_change && mode_match_safe[i]) begin
                    dirty_mode[i] <= 1'b0;
                end
            end
            dirty_modes <= |dirty_mode;
        end
    end

endmodule

`default_nettype wire

/* hw/video_timing_pkg.sv */
`default_nettype none

package video_timing_pkg;

    localparam int val_w = 16;

    // one programmed mode
    typedef struct packed {
        logic [val_w-1:0] sample_count;
        logic [val_w-1:0] line_count;
        logic [val_w-1:0] h_front_porch;
        logic [val_w-1:0] h_sync_length;
        logic [val_w-1:0] h_blank;
        logic [val_w-1:0] v_front_porch;
        logic [val_w-1:0] v_sync_length;
        logic [val_w-1:0] v_blank;
    } mode_cfg_t;

    // measured size of the incoming picture
    typedef struct packed {
        logic [val_w-1:0] samples;
        logic [val_w-1:0] lines;
    } video_meas_t;

    // values for the output counters
    typedef struct packed {
        logic [val_w-1:0] h_total_minus_one;
        logic [val_w-1:0] v_total_minus_one;
        logic [val_w-1:0] h_blank;
        logic [val_w-1:0] h_sync_start;
        logic [val_w-1:0] h_sync_end;
        logic [val_w-1:0] v_blank;
        logic [val_w-1:0] v_sync_start;
        logic [val_w-1:0] v_sync_end;
    } video_timing_t;

    // 720p, 1650 x 750 total
    localparam mode_cfg_t default_mode = '{
        sample_count:  16'd1280,
        line_count:    16'd720,
        h_front_porch: 16'd110,
        h_sync_length: 16'd40,
        h_blank:       16'd370,
        v_front_porch: 16'd5,
        v_sync_length: 16'd5,
        v_blank:       16'd30
    };

endpackage

`default_nettype wire

/* hw/mode_regs_pkg.sv */
`default_nettype none

package mode_regs_pkg;

    // bank size
    localparam int num_modes = 4;
    localparam int mode_idx_w = 2;

    // control port widths
    localparam int addr_w = 8;
    localparam int data_w = 16;

    // address layout, registers below mode_base_addr belong to the control block
    localparam int mode_base_addr = 4;
    localparam int regs_per_mode = 8;
    localparam int mode_stride = 9;

    // offsets within one mode
    localparam int reg_sample_count = 0;
    localparam int reg_line_count = 1;
    localparam int reg_h_front_porch = 2;
    localparam int reg_h_sync_length = 3;
    localparam int reg_h_blank = 4;
    localparam int reg_v_front_porch = 5;
    localparam int reg_v_sync_length = 6;
    localparam int reg_v_blank = 7;

    // bit 0 locks the mode
    localparam int reg_valid = 8;

    // one write on the control port
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire
